/* src/uart_pkg.sv */
package uart_pkg;

  // Serial line timing
  localparam int unsigned clks_per_bit = 16; // Clock cycles per serial bit
  localparam int unsigned clk_cnt_w    = $clog2(clks_per_bit); // Bit period counter width

  // Counter value at the last cycle of a bit period
  localparam logic [clk_cnt_w-1:0] bit_last = clk_cnt_w'(clks_per_bit - 1);
  // Counter value at the middle of the start bit
  localparam logic [clk_cnt_w-1:0] bit_mid  = clk_cnt_w'((clks_per_bit - 1) / 2);

  // One received 8N1 character
  // frame_err sits above data so the packed layout matches RXDATA bits 8..0
  typedef struct packed {
    logic       frame_err; // Stop bit sampled low
    logic [7:0] data;      // Received byte, LSB first on the line
  } rx_frame_t;

  // Receive FIFO sizing
  localparam int unsigned fifo_depth = 8;                   // Entries
  localparam int unsigned fifo_cnt_w = 4;                   // Holds 0 to fifo_depth
  localparam int unsigned fifo_ptr_w = $clog2(fifo_depth);  // Read and write pointer width

  // Fill count when every entry is taken
  localparam logic [fifo_cnt_w-1:0] fifo_full_cnt = fifo_cnt_w'(fifo_depth);
  // Highest pointer value before wrap
  localparam logic [fifo_ptr_w-1:0] fifo_ptr_last = fifo_ptr_w'(fifo_depth - 1);

endpackage

/* src/axil_pkg.sv */
package axil_pkg;

  // Bus widths
  localparam int unsigned addr_w = 4;          // Byte address covering four registers
  localparam int unsigned data_w = 32;
  localparam int unsigned strb_w = data_w / 8; // One strobe per byte lane

  // Host to slave
  typedef struct packed {
    logic              awvalid;
    logic [addr_w-1:0] awaddr;
    logic              wvalid;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] wstrb;
    logic              bready;
    logic              arvalid;
    logic [addr_w-1:0] araddr;
    logic              rready;
  } axil_req_t;

  // Slave to host
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [data_w-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  // Response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Register map
  localparam logic [addr_w-1:0] reg_rxdata = 4'h0; // Read pops one frame
  localparam logic [addr_w-1:0] reg_status = 4'h4; // Fill count and overflow
  localparam logic [addr_w-1:0] reg_ctrl   = 4'h8; // Write only

  // Field positions
  localparam int unsigned rxdata_valid_bit = 31; // Set when RXDATA returned a frame
  localparam int unsigned status_ovf_bit   = 4;  // Sticky overflow just above the count
  localparam int unsigned ctrl_clr_bit     = 0;  // Write 1 clears overflow

endpackage

/* src/uart_rx.sv */
module uart_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                serial_in,
  output uart_pkg::rx_frame_t frame,
  output logic                frame_valid
);

  typedef enum logic [2:0] {
    st_idle,    // Line high until a falling edge
    st_start,   // Confirm start bit at its middle
    st_data,    // Eight data bits, LSB first
    st_stop,    // Stop bit sample
    st_cleanup  // Wait for line to go high again
  } rx_state_t;

  logic [1:0]                     sync_q;   // Two-flop synchronizer
  logic                           rx_s;     // Synchronized line
  logic [uart_pkg::clk_cnt_w-1:0] clk_cnt;  // Cycles within current bit
  logic [2:0]                     bit_idx;  // Data bit being received
  logic                           bit_done; // Last cycle of a bit period
  logic                           data_smp; // Sample strobe for a data bit
  logic                           stop_smp; // Sample strobe for the stop bit
  rx_state_t                      state;

  assign rx_s     = sync_q[1];
  assign bit_done = (clk_cnt == uart_pkg::bit_last);
  assign data_smp = (state == st_data) && bit_done;
  assign stop_smp = (state == st_stop) && bit_done;

  // Idle line is high, so reset to 1 to avoid a false start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync_q <= 2'b11;
    end else begin
      sync_q <= {sync_q[0], serial_in};
    end
  end

  // Receive FSM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_idle;
      clk_cnt     <= '0;
      bit_idx     <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= 1'b0; // Pulses only on the stop sample
      case (state)
        st_idle: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!rx_s) state <= st_start; // Falling edge seen
        end

        st_start: begin
          if (clk_cnt == uart_pkg::bit_mid) begin
            clk_cnt <= '0;                         // Now aligned to bit centres
            state   <= rx_s ? st_idle : st_data;   // Glitch if line went back high
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        st_data: begin
          if (bit_done) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= st_stop; // Last data bit taken
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        st_stop: begin
          if (bit_done) begin
            clk_cnt     <= '0;
            frame_valid <= 1'b1;
            state       <= st_cleanup;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end

        // A low stop bit may be a break, so hold off until the line is high
        st_cleanup: if (rx_s) state <= st_idle;

        default: state <= st_idle;
      endcase
    end
  end

  // Frame payload captured at bit centres
  always_ff @(posedge clk) begin
    if (data_smp) frame.data[bit_idx] <= rx_s;
    if (stop_smp) frame.frame_err <= ~rx_s; // Stop must be high
  end

endmodule

/* src/rx_fifo.sv */
module rx_fifo (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                push,
  input  uart_pkg::rx_frame_t                 push_frame,
  input  logic                                pop,
  output uart_pkg::rx_frame_t                 head,
  output logic [uart_pkg::fifo_cnt_w-1:0]     count,
  output logic                                overflow,
  input  logic                                clr_overflow
);

  uart_pkg::rx_frame_t mem [uart_pkg::fifo_depth]; // Frame storage

  logic [uart_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [uart_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic                            full;
  logic                            do_push; // Push that actually lands

  // Advance with wrap for any depth
  function automatic logic [uart_pkg::fifo_ptr_w-1:0] ptr_next(
    input logic [uart_pkg::fifo_ptr_w-1:0] ptr
  );
    return (ptr == uart_pkg::fifo_ptr_last) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == uart_pkg::fifo_full_cnt);
  assign do_push = push && !full; // Full FIFO drops the frame
  assign head    = mem[rd_ptr];   // First-word fall-through

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_frame;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (pop)     rd_ptr <= ptr_next(rd_ptr); // Slave only pops when count is nonzero

      // Simultaneous push and pop leave count unchanged
      case ({do_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase

      // A new drop wins over a clear in the same cycle
      if (push && full) begin
        overflow <= 1'b1;
      end else if (clr_overflow) begin
        overflow <= 1'b0;
      end
    end
  end

endmodule

/* src/axil_rx_regs.sv */
module axil_rx_regs (
  input  logic                            clk,
  input  logic                            rst_n,
  input  axil_pkg::axil_req_t             req,
  output axil_pkg::axil_rsp_t             rsp,
  input  uart_pkg::rx_frame_t             head,
  input  logic [uart_pkg::fifo_cnt_w-1:0] count,
  input  logic                            overflow,
  output logic                            pop,
  output logic                            clr_overflow
);

  logic                        wr_accept; // AW and W taken together
  logic                        rd_accept;
  logic                        fifo_empty;
  logic [axil_pkg::data_w-1:0] rd_word;   // Decoded read data
  logic [1:0]                  rd_code;
  logic [1:0]                  wr_code;

  // Response registers
  logic                        bvalid_q;
  logic [1:0]                  bresp_q;
  logic                        rvalid_q;
  logic [axil_pkg::data_w-1:0] rdata_q;
  logic [1:0]                  rresp_q;

  assign fifo_empty = (count == '0);
  assign wr_accept  = req.awvalid && req.wvalid && !bvalid_q; // Readies are !bvalid_q
  assign rd_accept  = req.arvalid && !rvalid_q;

  // Read decode
  always_comb begin
    rd_word = '0;
    rd_code = axil_pkg::resp_okay;
    case (req.araddr)
      axil_pkg::reg_rxdata: begin
        if (!fifo_empty) begin
          rd_word[$bits(uart_pkg::rx_frame_t)-1:0] = head; // Byte and frame_err
          rd_word[axil_pkg::rxdata_valid_bit]      = 1'b1;
        end
      end
      axil_pkg::reg_status: begin
        rd_word[uart_pkg::fifo_cnt_w-1:0]     = count;
        rd_word[axil_pkg::status_ovf_bit]     = overflow;
      end
      default: rd_code = axil_pkg::resp_slverr; // Includes CTRL, which is write only
    endcase
  end

  // Only CTRL is writable
  assign wr_code = (req.awaddr == axil_pkg::reg_ctrl) ? axil_pkg::resp_okay
                                                      : axil_pkg::resp_slverr;

  // Side effects happen at acceptance
  assign pop          = rd_accept && (req.araddr == axil_pkg::reg_rxdata) && !fifo_empty;
  assign clr_overflow = wr_accept && (req.awaddr == axil_pkg::reg_ctrl) &&
                        req.wstrb[0] && req.wdata[axil_pkg::ctrl_clr_bit];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (req.bready) begin
        bvalid_q <= 1'b0; // Response taken
      end
      if (rd_accept) begin
        rvalid_q <= 1'b1;
      end else if (req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Payload loads only at acceptance, so it holds while the host stalls
  always_ff @(posedge clk) begin
    if (wr_accept) bresp_q <= wr_code;
    if (rd_accept) begin
      rdata_q <= rd_word;
      rresp_q <= rd_code;
    end
  end

  always_comb begin
    rsp.awready = !bvalid_q; // One write outstanding at most
    rsp.wready  = !bvalid_q;
    rsp.bvalid  = bvalid_q;
    rsp.bresp   = bresp_q;
    rsp.arready = !rvalid_q; // One read outstanding at most
    rsp.rvalid  = rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = rresp_q;
  end

endmodule

/* src/uart_rx_axil_top.sv */
module uart_rx_axil_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                serial_in,
  input  axil_pkg::axil_req_t axil_req,
  output axil_pkg::axil_rsp_t axil_rsp
);

  // Receiver to FIFO
  uart_pkg::rx_frame_t frame;
  logic                frame_valid; // One-cycle pulse without ready

  // FIFO to register slave
  uart_pkg::rx_frame_t                 head;
  logic [uart_pkg::fifo_cnt_w-1:0]     count;
  logic                                overflow;
  logic                                pop;
  logic                                clr_overflow;

  uart_rx i_uart_rx (
    .clk         (clk),
    .rst_n       (rst_n),
    .serial_in   (serial_in),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  rx_fifo i_rx_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (frame_valid),
    .push_frame   (frame),
    .pop          (pop),
    .head         (head),
    .count        (count),
    .overflow     (overflow),
    .clr_overflow (clr_overflow)
  );

  axil_rx_regs i_axil_rx_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (axil_req),
    .rsp          (axil_rsp),
    .head         (head),
    .count        (count),
    .overflow     (overflow),
    .pop          (pop),
    .clr_overflow (clr_overflow)
  );

endmodule

/* verif/uart_rx_axil_assert.sv */
module uart_rx_axil_assert (
  input logic                            clk,
  input logic                            rst_n,
  input axil_pkg::axil_req_t             axil_req,
  input axil_pkg::axil_rsp_t             axil_rsp,
  input logic                            pop,
  input logic [uart_pkg::fifo_cnt_w-1:0] count
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0; // Failed assertions seen so far

  // Read response holds with stable payload until rready
  rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=>
      axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
    else begin
      $error("rvalid dropped or read data changed before rready");
      fail_cnt++;
    end

  // Write response holds until bready
  bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else begin
      $error("bvalid dropped or bresp changed before bready");
      fail_cnt++;
    end

  // An empty pop would wrap the count upwards
  pop_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop |=> count <= $past(count))
    else begin
      $error("FIFO count grew or wrapped after a pop");
      fail_cnt++;
    end

  count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= uart_pkg::fifo_full_cnt)
    else begin
      $error("FIFO count above depth");
      fail_cnt++;
    end

endmodule

bind uart_rx_axil_top uart_rx_axil_assert i_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .pop      (pop),
  .count    (count)
);

/* verif/tb_uart_rx_axil.sv */
module tb_uart_rx_axil;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned num_cases = 7;
  localparam int unsigned bit_ns    = uart_pkg::clks_per_bit * 4;    // One serial bit in ns
  localparam int unsigned limit_ns  = (num_cases + 12) * 12 * bit_ns; // Watchdog budget

  logic                clk;
  logic                rst_n;
  logic                serial_in;
  axil_pkg::axil_req_t axil_req;
  axil_pkg::axil_rsp_t axil_rsp;

  int unsigned mismatch_cnt;
  int unsigned other_cnt; // Failures that are not a wrong value

  // Expected word is {valid, 22'b0, frame_err, byte}
  string       case_name [num_cases] = '{"byte_55", "byte_a3", "byte_00", "byte_ff",
                                         "byte_3c", "ferr_96", "ferr_01"};
  logic [7:0]  case_data [num_cases] = '{8'h55, 8'ha3, 8'h00, 8'hff, 8'h3c, 8'h96, 8'h01};
  logic        case_stop [num_cases] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
  logic [31:0] case_word [num_cases] = '{32'h8000_0055, 32'h8000_00a3, 32'h8000_0000,
                                         32'h8000_00ff, 32'h8000_003c, 32'h8000_0196,
                                         32'h8000_0101};

  uart_rx_axil_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .serial_in (serial_in),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    #(limit_ns);
    $display("timeout: run did not finish within %0d ns", limit_ns);
    $display("Test failed");
    $finish;
  end

  // Step to 1 ns after the n-th rising edge
  task automatic next_cycle(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // 8N1 character LSB first followed by a short random idle gap
  task automatic send_char(input logic [7:0] data, input logic stop);
    serial_in = 1'b0; // Start bit
    next_cycle(uart_pkg::clks_per_bit);
    for (int i = 0; i < 8; i++) begin
      serial_in = data[i];
      next_cycle(uart_pkg::clks_per_bit);
    end
    serial_in = stop;
    next_cycle(uart_pkg::clks_per_bit);
    serial_in = 1'b1;
    next_cycle(3 + $urandom % 4); // Long enough for the FSM to leave cleanup
  endtask

  // Read with rready held low for hold cycles after rvalid
  task automatic axil_read(input string name, input logic [axil_pkg::addr_w-1:0] addr,
                           input int unsigned hold, output logic [31:0] data,
                           output logic [1:0] resp);
    logic [31:0] first;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    while (!axil_rsp.arready) next_cycle(1);
    next_cycle(1);             // Address taken on this edge
    axil_req.arvalid = 1'b0;
    check_value({name, " rvalid"}, 32'd1, 32'(axil_rsp.rvalid)); // One cycle after accept
    first = axil_rsp.rdata;
    repeat (hold) begin
      next_cycle(1);
      check_value({name, " rvalid held"}, 32'd1, 32'(axil_rsp.rvalid));
      check_value({name, " rdata held"}, first, axil_rsp.rdata);
    end
    check_value({name, " arready low"}, 32'd0, 32'(axil_rsp.arready)); // Response pending
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.rready = 1'b1;
    next_cycle(1);
    axil_req.rready = 1'b0;
    check_value({name, " arready high"}, 32'd1, 32'(axil_rsp.arready));
  endtask

  task automatic axil_write(input string name, input logic [axil_pkg::addr_w-1:0] addr,
                            input logic [31:0] data, output logic [1:0] resp);
    int unsigned hold;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    while (!axil_rsp.awready || !axil_rsp.wready) next_cycle(1);
    next_cycle(1);             // AW and W taken together
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    check_value({name, " bvalid"}, 32'd1, 32'(axil_rsp.bvalid));
    resp = axil_rsp.bresp;
    hold = $urandom % 4;       // Random bready delay
    repeat (hold) begin
      next_cycle(1);
      check_value({name, " bvalid held"}, 32'd1, 32'(axil_rsp.bvalid));
      check_value({name, " bresp held"}, 32'(resp), 32'(axil_rsp.bresp));
    end
    check_value({name, " aw w ready low"}, 32'd0,
                32'({axil_rsp.awready, axil_rsp.wready}));
    axil_req.bready = 1'b1;
    next_cycle(1);
    axil_req.bready = 1'b0;
    check_value({name, " aw w ready high"}, 32'd3,
                32'({axil_rsp.awready, axil_rsp.wready}));
  endtask

  // Poll STATUS until the FIFO holds at least n frames
  task automatic wait_count(input string name, input int unsigned n);
    logic [31:0] status;
    logic [1:0]  resp;
    int unsigned polls;
    polls = 0;
    do begin
      axil_read(name, axil_pkg::reg_status, 0, status, resp);
      polls++;
    end while (32'(status[3:0]) < n && polls < 4 * uart_pkg::clks_per_bit);
    if (32'(status[3:0]) < n) begin
      other_cnt++;
      $display("%s: FIFO count never reached %0d", name, n);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [1:0]  resp;
    logic [31:0] exp_word;
    string       name;
    mismatch_cnt = 0;
    other_cnt    = 0;
    void'($urandom(32'hf9b5));
    rst_n        = 1'b0;
    serial_in    = 1'b1; // Idle line
    axil_req     = '0;
    next_cycle(3);
    rst_n = 1'b1;

    // Empty after reset
    check_value("reset_ready", 32'h7,
                32'({axil_rsp.awready, axil_rsp.wready, axil_rsp.arready}));
    axil_read("reset_status", axil_pkg::reg_status, 0, rd, resp);
    check_value("reset_status", 32'h0, rd);
    check_value("reset_status resp", 32'(axil_pkg::resp_okay), 32'(resp));
    axil_read("reset_rxdata", axil_pkg::reg_rxdata, 0, rd, resp);
    check_value("reset_rxdata", 32'h0, rd);
    check_value("reset_rxdata resp", 32'(axil_pkg::resp_okay), 32'(resp));

    for (int i = 0; i < num_cases; i++) begin
      send_char(case_data[i], case_stop[i]);
      wait_count(case_name[i], 1);
      axil_read(case_name[i], axil_pkg::reg_rxdata, 0, rd, resp);
      check_value(case_name[i], case_word[i], rd);
      check_value({case_name[i], " resp"}, 32'(axil_pkg::resp_okay), 32'(resp));
    end

    // Send two more characters than the FIFO holds without reading
    for (int i = 0; i < uart_pkg::fifo_depth + 2; i++) send_char(8'h10 + 8'(i), 1'b1);
    wait_count("overflow_fill", uart_pkg::fifo_depth);
    axil_read("overflow_status", axil_pkg::reg_status, 0, rd, resp);
    check_value("overflow_status", 32'h10 | uart_pkg::fifo_depth, rd);

    // Bad addresses leave the FIFO untouched
    axil_read("bad_read", 4'hc, 0, rd, resp);
    check_value("bad_read rdata", 32'h0, rd);
    check_value("bad_read resp", 32'(axil_pkg::resp_slverr), 32'(resp));
    axil_write("bad_write", 4'hc, 32'h1, resp);
    check_value("bad_write resp", 32'(axil_pkg::resp_slverr), 32'(resp));
    axil_write("rxdata_write", axil_pkg::reg_rxdata, 32'h1, resp);
    check_value("rxdata_write resp", 32'(axil_pkg::resp_slverr), 32'(resp));
    axil_read("decode_status", axil_pkg::reg_status, 0, rd, resp);
    check_value("decode_status", 32'h10 | uart_pkg::fifo_depth, rd);

    // Drain under read back-pressure with one pop per read
    for (int i = 0; i < uart_pkg::fifo_depth; i++) begin
      name     = $sformatf("drain_%0d", i);
      exp_word = 32'h8000_0000 | 32'(8'h10 + 8'(i)); // Oldest frames were kept
      axil_read(name, axil_pkg::reg_rxdata, 1 + $urandom % 8, rd, resp);
      check_value(name, exp_word, rd);
      axil_read({name, " status"}, axil_pkg::reg_status, 0, rd, resp);
      check_value({name, " status"}, 32'h10 | 32'(uart_pkg::fifo_depth - 1 - i), rd);
    end

    axil_write("clr_overflow", axil_pkg::reg_ctrl, 32'h1, resp);
    check_value("clr_overflow resp", 32'(axil_pkg::resp_okay), 32'(resp));
    axil_read("clr_status", axil_pkg::reg_status, 0, rd, resp);
    check_value("clr_status", 32'h0, rd);

    $display("errors: %0d mismatch, %0d other, %0d assertion", mismatch_cnt, other_cnt,
             i_dut.i_assert.fail_cnt);
    if (mismatch_cnt + other_cnt + i_dut.i_assert.fail_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/uart_pkg.sv
src/axil_pkg.sv
src/uart_rx.sv
src/rx_fifo.sv
src/axil_rx_regs.sv
src/uart_rx_axil_top.sv
verif/uart_rx_axil_assert.sv
verif/tb_uart_rx_axil.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --top-module tb_uart_rx_axil \
  -f filelist.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Raise the error limit so assertion errors do not stop the run early
sim_out="$(./obj_dir/sim_tb +verilator+error+limit+100 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
